// File: floppy_bus_pkg.sv
package floppy_bus_pkg;

	////////////////////////////////
	// Bus-side vectors
	////////////////////////////////

	// Full CPU address
	typedef logic [15:0] cpu_addr_t;

	// Data byte on the bus
	typedef logic [7:0] cpu_byte_t;

	// Index into the 512-byte low memory
	typedef logic [8:0] zp_addr_t;

endpackage

// File: floppy_io.sv
module floppy_io (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      ce,
	input  logic                      memwr,
	input  floppy_bus_pkg::cpu_addr_t addr,
	input  floppy_bus_pkg::cpu_byte_t wdata,
	output floppy_bus_pkg::cpu_byte_t rdata,
	input  logic                      sd_miso,
	output logic                      sd_mosi,
	output logic                      sd_sck,
	output logic                      uart_txd,
	output floppy_bus_pkg::cpu_byte_t green_leds
);
	import floppy_bus_pkg::*;

	// Reset vector bytes
	localparam cpu_byte_t VEC_ODD  = 8'h08;
	localparam cpu_byte_t VEC_EVEN = 8'h00;

	logic      in_low;
	logic      in_vec;
	logic      zp_wren;
	cpu_byte_t zp_q;
	cpu_byte_t port_q;

	////////////////////////////////
	// Region decode
	////////////////////////////////

	// Below 0x0200
	assign in_low = (addr[15:9] == 7'd0);
	// 0xFFF0 to 0xFFFF
	assign in_vec = &addr[15:4];

	assign zp_wren = ce & memwr & in_low;

	// Vector window wins over everything
	assign rdata = in_vec ? (addr[0] ? VEC_ODD : VEC_EVEN) :
	               in_low ? zp_q : port_q;

	floppy_zeropage zeropage (
		.clk(clk),
		.wren(zp_wren),
		.addr(zp_addr_t'(addr[8:0])),
		.wdata(wdata),
		.rdata(zp_q)
	);

	floppy_io_ports ports (
		.clk(clk), .reset_n(reset_n), .ce(ce), .memwr(memwr),
		.addr(addr), .wdata(wdata), .rdata(port_q),
		.sd_miso(sd_miso), .sd_mosi(sd_mosi), .sd_sck(sd_sck),
		.uart_txd(uart_txd), .green_leds(green_leds)
	);

endmodule

// File: floppy_io_ports.sv
`include "floppy_macros.svh"

module floppy_io_ports (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      ce,
	input  logic                      memwr,
	input  floppy_bus_pkg::cpu_addr_t addr,
	input  floppy_bus_pkg::cpu_byte_t wdata,
	output floppy_bus_pkg::cpu_byte_t rdata,
	input  logic                      sd_miso,
	output logic                      sd_mosi,
	output logic                      sd_sck,
	output logic                      uart_txd,
	output floppy_bus_pkg::cpu_byte_t green_leds
);
	import floppy_bus_pkg::*;
	import floppy_periph_pkg::*;

	// Absolute port addresses
	localparam cpu_addr_t ADDR_MMCA = `FLOPPY_IOBASE + `FLOPPY_PORT_MMCA;
	localparam cpu_addr_t ADDR_SPDR = `FLOPPY_IOBASE + `FLOPPY_PORT_SPDR;
	localparam cpu_addr_t ADDR_TXD  = `FLOPPY_IOBASE + `FLOPPY_PORT_TXD;
	localparam cpu_addr_t ADDR_CTL  = `FLOPPY_IOBASE + `FLOPPY_PORT_CTL;
	localparam cpu_addr_t ADDR_TMR1 = `FLOPPY_IOBASE + `FLOPPY_PORT_TMR1;
	localparam cpu_addr_t ADDR_TMR2 = `FLOPPY_IOBASE + `FLOPPY_PORT_TMR2;
	localparam cpu_addr_t ADDR_LED  = `FLOPPY_IOBASE + `FLOPPY_PORT_LED;

	logic           bus_wr;
	cpu_byte_t      timer1_q;
	cpu_byte_t      timer2_q;
	cpu_byte_t      spi_q;
	logic           spi_ready;
	tx_feed_state_t feed_state;
	cpu_byte_t      tx_byte;
	logic           tx_load;
	logic           tx_busy;
	logic           tx_status;

	assign bus_wr = ce & memwr;

	////////////////////////////////
	// Read mux
	////////////////////////////////

	assign tx_status = (feed_state != FEED_IDLE) | tx_busy;

	always_comb begin
		case (addr)
			ADDR_MMCA: rdata = {7'b0, spi_ready};
			ADDR_SPDR: rdata = spi_q;
			ADDR_CTL:  rdata = {7'b0, tx_status};
			ADDR_TMR1: rdata = timer1_q;
			ADDR_TMR2: rdata = timer2_q;
			ADDR_LED:  rdata = green_leds;
			default:   rdata = 8'hFF;
		endcase
	end

	////////////////////////////////
	// LEDs and UART feed
	////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			green_leds <= '0;
			feed_state <= FEED_IDLE;
			tx_load    <= 1'b0;
		end else begin
			tx_load <= 1'b0;
			if (bus_wr && addr == ADDR_LED) begin
				green_leds <= wdata;
			end
			// A new byte replaces whatever is still pending
			if (bus_wr && addr == ADDR_TXD) begin
				tx_byte    <= wdata;
				feed_state <= FEED_WAIT_FREE;
			end else begin
				case (feed_state)
					FEED_WAIT_FREE: begin
						if (!tx_busy) begin
							tx_load    <= 1'b1;
							feed_state <= FEED_WAIT_BUSY;
						end
					end
					FEED_WAIT_BUSY: begin
						if (tx_busy) feed_state <= FEED_IDLE;
					end
					default: feed_state <= FEED_IDLE;
				endcase
			end
		end
	end

	floppy_uart_tx #(.CLKS_PER_BIT(`FLOPPY_UART_DIV)) uart (
		.clk(clk), .reset_n(reset_n), .load(tx_load), .data(tx_byte),
		.txd(uart_txd), .busy(tx_busy)
	);

	floppy_timer #(.DIV(`FLOPPY_TIMER_DIV)) timer1 (
		.clk(clk), .reset_n(reset_n), .load(bus_wr && addr == ADDR_TMR1),
		.wdata(wdata), .count(timer1_q)
	);

	floppy_timer #(.DIV(`FLOPPY_TIMER_DIV)) timer2 (
		.clk(clk), .reset_n(reset_n), .load(bus_wr && addr == ADDR_TMR2),
		.wdata(wdata), .count(timer2_q)
	);

	floppy_spi #(.HALF(`FLOPPY_SPI_HALF)) spi (
		.clk(clk), .reset_n(reset_n), .start(bus_wr && addr == ADDR_SPDR),
		.wdata(wdata), .miso(sd_miso), .mosi(sd_mosi), .sck(sd_sck),
		.rdata(spi_q), .ready(spi_ready)
	);

endmodule

// File: floppy_macros.svh
`ifndef FLOPPY_MACROS_SVH
`define FLOPPY_MACROS_SVH

// I/O page base address
`define FLOPPY_IOBASE       16'hE000

// Port offsets inside the I/O page
`define FLOPPY_PORT_MMCA    16'd0
`define FLOPPY_PORT_SPDR    16'd1
`define FLOPPY_PORT_TXD     16'd4
`define FLOPPY_PORT_CTL     16'd6
`define FLOPPY_PORT_TMR1    16'd7
`define FLOPPY_PORT_TMR2    16'd8
`define FLOPPY_PORT_LED     16'd16

// Clock cycles per serial bit
`define FLOPPY_UART_DIV     8

// Clock cycles per timer decrement
`define FLOPPY_TIMER_DIV    16

// Half period of SCK in clock cycles
`define FLOPPY_SPI_HALF     2

`endif

// File: floppy_periph_pkg.sv
package floppy_periph_pkg;

	// Serial transmitter frame phases
	typedef enum logic [1:0] {
		TX_IDLE, TX_START, TX_DATA, TX_STOP
	} uart_tx_state_t;

	// Byte handoff from the TXD port to the transmitter
	typedef enum logic [1:0] {
		FEED_IDLE, FEED_WAIT_FREE, FEED_WAIT_BUSY
	} tx_feed_state_t;

	// SPI clock phases
	typedef enum logic [1:0] {
		SPI_IDLE, SPI_LOW, SPI_HIGH
	} spi_state_t;

endpackage

// File: floppy_spi.sv
`include "floppy_macros.svh"

module floppy_spi #(
	parameter int HALF = `FLOPPY_SPI_HALF
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      start,
	input  floppy_bus_pkg::cpu_byte_t wdata,
	input  logic                      miso,
	output logic                      mosi,
	output logic                      sck,
	output floppy_bus_pkg::cpu_byte_t rdata,
	output logic                      ready
);
	import floppy_bus_pkg::*;
	import floppy_periph_pkg::*;

	localparam int HW = (HALF > 1) ? $clog2(HALF) : 1;
	localparam logic [HW-1:0] LAST_CLK = HW'(HALF - 1);

	spi_state_t    state;
	logic [HW-1:0] half_clk;
	logic [2:0]    bit_idx;
	// Outgoing bits leave at the top and incoming ones enter at the bottom
	cpu_byte_t     shreg;

	assign ready = (state == SPI_IDLE);
	assign rdata = shreg;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state    <= SPI_IDLE;
			sck      <= 1'b0;
			mosi     <= 1'b0;
			half_clk <= '0;
			bit_idx  <= '0;
		end else begin
			case (state)
				SPI_IDLE: begin
					if (start) begin
						shreg    <= wdata;
						mosi     <= wdata[7];
						half_clk <= '0;
						bit_idx  <= '0;
						state    <= SPI_LOW;
					end
				end
				SPI_LOW: begin
					if (half_clk == LAST_CLK) begin
						// Rising SCK samples MISO
						half_clk <= '0;
						sck      <= 1'b1;
						shreg    <= {shreg[6:0], miso};
						state    <= SPI_HIGH;
					end else begin
						half_clk <= half_clk + 1'b1;
					end
				end
				SPI_HIGH: begin
					if (half_clk == LAST_CLK) begin
						half_clk <= '0;
						sck      <= 1'b0;
						if (bit_idx == 3'd7) begin
							state <= SPI_IDLE;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							mosi    <= shreg[7];
							state   <= SPI_LOW;
						end
					end else begin
						half_clk <= half_clk + 1'b1;
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

endmodule

// File: floppy_timer.sv
`include "floppy_macros.svh"

module floppy_timer #(
	parameter int DIV = `FLOPPY_TIMER_DIV
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      load,
	input  floppy_bus_pkg::cpu_byte_t wdata,
	output floppy_bus_pkg::cpu_byte_t count
);
	localparam int PW = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [PW-1:0] LAST_TICK = PW'(DIV - 1);

	logic [PW-1:0] prescale;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			prescale <= '0;
			count    <= '0;
		end else if (load) begin
			// New count restarts the prescaler
			prescale <= '0;
			count    <= wdata;
		end else if (prescale == LAST_TICK) begin
			prescale <= '0;
			// Holds at zero
			if (count != '0) begin
				count <= count - 1'b1;
			end
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// File: floppy_uart_tx.sv
`include "floppy_macros.svh"

module floppy_uart_tx #(
	parameter int CLKS_PER_BIT = `FLOPPY_UART_DIV
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      load,
	input  floppy_bus_pkg::cpu_byte_t data,
	output logic                      txd,
	output logic                      busy
);
	import floppy_bus_pkg::*;
	import floppy_periph_pkg::*;

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CW-1:0] LAST_CLK = CW'(CLKS_PER_BIT - 1);

	uart_tx_state_t state;
	logic [CW-1:0]  bit_clk;
	logic [2:0]     bit_idx;
	cpu_byte_t      shreg;

	assign busy = (state != TX_IDLE);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state   <= TX_IDLE;
			txd     <= 1'b1;
			bit_clk <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					txd     <= 1'b1;
					bit_clk <= '0;
					if (load) begin
						// Start bit goes out right away
						shreg <= data;
						txd   <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_clk == LAST_CLK) begin
						bit_clk <= '0;
						bit_idx <= '0;
						txd     <= shreg[0];
						shreg   <= {1'b0, shreg[7:1]};
						state   <= TX_DATA;
					end else begin
						bit_clk <= bit_clk + 1'b1;
					end
				end
				TX_DATA: begin
					if (bit_clk == LAST_CLK) begin
						bit_clk <= '0;
						if (bit_idx == 3'd7) begin
							txd   <= 1'b1;
							state <= TX_STOP;
						end else begin
							// LSB first
							bit_idx <= bit_idx + 1'b1;
							txd     <= shreg[0];
							shreg   <= {1'b0, shreg[7:1]};
						end
					end else begin
						bit_clk <= bit_clk + 1'b1;
					end
				end
				TX_STOP: begin
					if (bit_clk == LAST_CLK) begin
						bit_clk <= '0;
						state   <= TX_IDLE;
					end else begin
						bit_clk <= bit_clk + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// File: floppy_zeropage.sv
module floppy_zeropage (
	input  logic                    clk,
	input  logic                    wren,
	input  floppy_bus_pkg::zp_addr_t  addr,
	input  floppy_bus_pkg::cpu_byte_t wdata,
	output floppy_bus_pkg::cpu_byte_t rdata
);
	import floppy_bus_pkg::*;

	localparam int DEPTH = 512;

	// Low memory array is undefined until written
	cpu_byte_t mem [0:DEPTH-1];

	// Read path is combinational
	assign rdata = mem[addr];

	always_ff @(posedge clk) begin
		if (wren) begin
			mem[addr] <= wdata;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the floppy I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_floppy \
	-f src.f -Mdir obj_dir -o sim_floppy
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_floppy > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

// File: src.f
+incdir+.
floppy_bus_pkg.sv
floppy_periph_pkg.sv
floppy_zeropage.sv
floppy_uart_tx.sv
floppy_timer.sv
floppy_spi.sv
floppy_io_ports.sv
floppy_io.sv
tb_floppy_clock.sv
tb_floppy_checker.sv
tb_floppy.sv

// File: tb_floppy.sv
`include "floppy_macros.svh"

module tb_floppy;
	import floppy_bus_pkg::*;

	localparam cpu_addr_t A_MMCA = `FLOPPY_IOBASE + `FLOPPY_PORT_MMCA;
	localparam cpu_addr_t A_SPDR = `FLOPPY_IOBASE + `FLOPPY_PORT_SPDR;
	localparam cpu_addr_t A_TXD  = `FLOPPY_IOBASE + `FLOPPY_PORT_TXD;
	localparam cpu_addr_t A_CTL  = `FLOPPY_IOBASE + `FLOPPY_PORT_CTL;
	localparam cpu_addr_t A_TMR1 = `FLOPPY_IOBASE + `FLOPPY_PORT_TMR1;
	localparam cpu_addr_t A_TMR2 = `FLOPPY_IOBASE + `FLOPPY_PORT_TMR2;
	localparam cpu_addr_t A_LED  = `FLOPPY_IOBASE + `FLOPPY_PORT_LED;

	// Rough cycle budget per test
	localparam int LEN_LOW  = 300;
	localparam int LEN_DEC  = 200;
	localparam int LEN_TMR  = 700;
	localparam int LEN_UART = 8 * (10 * `FLOPPY_UART_DIV + 30);
	localparam int LEN_SPI  = 8 * (16 * `FLOPPY_SPI_HALF + 20);
	localparam int LIMIT = (LEN_LOW + LEN_DEC + LEN_TMR + LEN_UART + LEN_SPI) * 5 / 4;

	logic        clk;
	logic        reset_n;
	logic        ce;
	logic        memwr;
	cpu_addr_t   addr;
	cpu_byte_t   wdata;
	cpu_byte_t   rdata;
	logic        sd_miso;
	logic        sd_mosi;
	logic        sd_sck;
	logic        uart_txd;
	cpu_byte_t   green_leds;
	logic        run_done;
	int          errors;
	int          checks;
	int          cycles = 0;
	logic [31:0] lfsr;
	logic [31:0] r;
	cpu_byte_t   q;
	cpu_byte_t   slave;
	cpu_addr_t   zp_list [64];

	tb_floppy_clock clock_gen (.clk(clk), .reset_n(reset_n));

	floppy_io i_dut (.*);

	tb_floppy_checker i_chk (.*);

	// SD card side shift register
	assign sd_miso = slave[7];
	always @(negedge sd_sck) slave = {slave[6:0], 1'b0};

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic bus_write(input cpu_addr_t a, input cpu_byte_t d);
		addr = a;
		wdata = d;
		ce = 1'b1;
		memwr = 1'b1;
		@(negedge clk);
		ce = 1'b0;
		memwr = 1'b0;
	endtask

	task automatic bus_read(input cpu_addr_t a, output cpu_byte_t d);
		addr = a;
		memwr = 1'b0;
		ce = 1'b1;
		#1 d = rdata;
		@(negedge clk);
		ce = 1'b0;
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors so far", name, errors);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("The run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		ce = 1'b0;
		memwr = 1'b0;
		addr = '0;
		wdata = '0;
		slave = '0;
		run_done = 1'b0;
		lfsr = 32'h6dcb68dd;
		@(posedge reset_n);
		@(negedge clk);

		////////////////////////////////
		// Low memory and vectors
		for (int i = 0; i < 64; i++) begin
			r = random_bits(17);
			zp_list[i] = cpu_addr_t'(r[16:8]);
			bus_write(zp_list[i], r[7:0]);
			bus_read(zp_list[i], q);
		end
		// Second pass over the same addresses catches aliasing
		for (int i = 0; i < 64; i++) bus_read(zp_list[i], q);
		for (int i = 0; i < 16; i++) bus_read(16'hFFF0 + cpu_addr_t'(i), q);
		report_test("low memory");

		////////////////////////////////
		// Decode and LEDs
		for (int i = 0; i < 32; i++) bus_read(`FLOPPY_IOBASE + cpu_addr_t'(i), q);
		for (int i = 0; i < 32; i++) begin
			r = random_bits(16);
			bus_read(r[15:0], q);
		end
		r = random_bits(8);
		bus_write(A_LED, r[7:0]);
		bus_read(A_LED, q);
		// Write strobe with ce low must be ignored
		addr = A_LED;
		wdata = ~r[7:0];
		memwr = 1'b1;
		@(negedge clk);
		memwr = 1'b0;
		bus_read(A_LED, q);
		report_test("decode");

		////////////////////////////////
		// Timers
		r = random_bits(16);
		bus_write(A_TMR1, r[7:0]);
		bus_write(A_TMR2, r[15:8]);
		for (int i = 0; i < 8; i++) begin
			r = random_bits(6);
			repeat (r[5:0]) @(negedge clk);
			bus_read(A_TMR1, q);
			bus_read(A_TMR2, q);
		end
		bus_write(A_TMR1, 8'd3);
		repeat (5 * `FLOPPY_TIMER_DIV) @(negedge clk);
		bus_read(A_TMR1, q);
		report_test("timers");

		////////////////////////////////
		// UART
		for (int i = 0; i < 8; i++) begin
			do bus_read(A_CTL, q); while (q[0]);
			r = random_bits(8);
			bus_write(A_TXD, r[7:0]);
		end
		do bus_read(A_CTL, q); while (q[0]);
		report_test("UART");

		////////////////////////////////
		// SPI
		for (int i = 0; i < 8; i++) begin
			r = random_bits(8);
			slave = r[7:0];
			r = random_bits(8);
			bus_write(A_SPDR, r[7:0]);
			do bus_read(A_MMCA, q); while (!q[0]);
			bus_read(A_SPDR, q);
		end
		report_test("SPI");

		run_done = 1'b1;
		@(negedge clk);

		$display("Checks done %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: tb_floppy_checker.sv
`include "floppy_macros.svh"

module tb_floppy_checker (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      ce,
	input  logic                      memwr,
	input  floppy_bus_pkg::cpu_addr_t addr,
	input  floppy_bus_pkg::cpu_byte_t wdata,
	input  floppy_bus_pkg::cpu_byte_t rdata,
	input  logic                      sd_miso,
	input  logic                      sd_mosi,
	input  logic                      sd_sck,
	input  logic                      uart_txd,
	input  floppy_bus_pkg::cpu_byte_t green_leds,
	input  logic                      run_done,
	output int                        errors,
	output int                        checks
);
	import floppy_bus_pkg::*;

	localparam cpu_addr_t A_MMCA = `FLOPPY_IOBASE + `FLOPPY_PORT_MMCA;
	localparam cpu_addr_t A_SPDR = `FLOPPY_IOBASE + `FLOPPY_PORT_SPDR;
	localparam cpu_addr_t A_TXD  = `FLOPPY_IOBASE + `FLOPPY_PORT_TXD;
	localparam cpu_addr_t A_CTL  = `FLOPPY_IOBASE + `FLOPPY_PORT_CTL;
	localparam cpu_addr_t A_TMR1 = `FLOPPY_IOBASE + `FLOPPY_PORT_TMR1;
	localparam cpu_addr_t A_TMR2 = `FLOPPY_IOBASE + `FLOPPY_PORT_TMR2;
	localparam cpu_addr_t A_LED  = `FLOPPY_IOBASE + `FLOPPY_PORT_LED;

	cpu_byte_t ram [int];
	cpu_byte_t led_m = '0;
	cpu_byte_t tmr_val [2] = '{8'd0, 8'd0};
	int        tmr_at [2] = '{0, 0};
	int        cyc = 0;
	cpu_byte_t uart_q [$];
	cpu_byte_t spi_q [$];
	cpu_byte_t spi_rx;
	logic      spi_valid = 1'b0;
	cpu_byte_t mosi_sr;
	cpu_byte_t miso_sr;
	int        spi_bits = 0;
	logic      u_on = 1'b0;
	int        u_ph;
	cpu_byte_t u_sr;

	initial begin
		errors = 0;
		checks = 0;
	end

	task automatic compare(input cpu_byte_t got, input cpu_byte_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic problem(input string msg);
		errors++;
		$display("At %0t: %s", $time, msg);
	endtask

	// Loaded value less the whole prescaler periods since the load edge and never below zero
	function automatic cpu_byte_t timer_now(input int t);
		int dec;
		dec = (cyc - tmr_at[t] - 1) / `FLOPPY_TIMER_DIV;
		return (dec >= tmr_val[t]) ? 8'd0 : cpu_byte_t'(tmr_val[t] - dec);
	endfunction

	task automatic check_read(input cpu_addr_t a, input cpu_byte_t d);
		if (a >= 16'hFFF0) begin
			compare(d, a[0] ? 8'h08 : 8'h00, "vector window");
		end else if (a < 16'h0200) begin
			if (ram.exists(int'(a))) compare(d, ram[int'(a)], "low memory");
		end else begin
			case (a)
				A_MMCA: begin
					compare({d[7:1], 1'b0}, 8'h00, "MMCA upper bits");
					if (d[0] && sd_sck) problem("SD clock is high while SPI reports ready");
				end
				A_CTL:  compare({d[7:1], 1'b0}, 8'h00, "CTL upper bits");
				A_SPDR: if (spi_valid) compare(d, spi_rx, "SPDR");
				A_TMR1: compare(d, timer_now(0), "timer 1");
				A_TMR2: compare(d, timer_now(1), "timer 2");
				A_LED:  compare(d, led_m, "LED port");
				default: compare(d, 8'hFF, "unused address");
			endcase
		end
	endtask

	always @(posedge clk) begin
		if (reset_n) begin
			cyc++;
			compare(green_leds, led_m, "green_leds");
			if (ce && !memwr) check_read(addr, rdata);
			if (ce && memwr) begin
				if (addr < 16'h0200) ram[int'(addr)] = wdata;
				case (addr)
					A_LED:  led_m = wdata;
					A_TXD:  uart_q.push_back(wdata);
					A_SPDR: spi_q.push_back(wdata);
					A_TMR1: begin
						tmr_val[0] = wdata;
						tmr_at[0] = cyc;
					end
					A_TMR2: begin
						tmr_val[1] = wdata;
						tmr_at[1] = cyc;
					end
					default: ;
				endcase
			end
			// Frame decoder samples each bit in its middle
			if (u_on) begin
				u_ph++;
				if (u_ph % `FLOPPY_UART_DIV == `FLOPPY_UART_DIV / 2) begin
					if (u_ph / `FLOPPY_UART_DIV == 0) begin
						if (uart_txd) problem("UART start bit did not stay low");
					end else if (u_ph / `FLOPPY_UART_DIV <= 8) begin
						u_sr = {uart_txd, u_sr[7:1]};
					end else begin
						if (!uart_txd) problem("UART stop bit is low");
						if (uart_q.size() == 0) problem("UART sent a frame with no byte written");
						else compare(u_sr, uart_q.pop_front(), "UART frame");
						u_on = 1'b0;
					end
				end
			end else if (!uart_txd) begin
				u_on = 1'b1;
				u_ph = 0;
			end
		end
	end

	always @(posedge sd_sck) begin
		mosi_sr = {mosi_sr[6:0], sd_mosi};
		miso_sr = {miso_sr[6:0], sd_miso};
		spi_bits++;
		if (spi_bits == 8) begin
			spi_bits = 0;
			if (spi_q.size() == 0) problem("SPI clocked a byte that was never written");
			else compare(mosi_sr, spi_q.pop_front(), "SPI MOSI byte");
			spi_rx = miso_sr;
			spi_valid = 1'b1;
		end
	end

	// Every written byte has left on its line by the end of the run
	always @(posedge run_done) begin
		if (uart_q.size() != 0) problem("UART did not send every byte written to TXD");
		if (spi_q.size() != 0) problem("SPI did not clock out every byte written to SPDR");
	end

endmodule

// File: tb_floppy_clock.sv
module tb_floppy_clock (
	output logic clk,
	output logic reset_n
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset held low for two clock periods
	initial begin
		reset_n = 1'b0;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;
	end

endmodule
